/* cache_perf_monitor.f */
common/perf_pkg.sv
common/byte_stream_if.sv
src/event_edge_counter.sv
src/snapshot_timer.sv
src/level_reporter.sv
src/report_arbiter.sv
src/cache_perf_monitor.sv
sim/tb_cache_perf_monitor.sv

/* sim/tb_cache_perf_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_perf_monitor;

	localparam int SNAP_PERIOD    = 64;
	localparam int PHASE1_CYCLES  = 40 * SNAP_PERIOD;
	localparam int STALL_CYCLES   = 150;
	localparam int WRAP_CYCLES    = 5000;
	localparam int DRAIN_CYCLES   = 2 * SNAP_PERIOD;
	localparam int TIMEOUT_CYCLES = 12000;	// Full run is about 7900 cycles
	localparam int MIN_RECORDS    = 300;

	logic        clk;
	logic        rstn;
	logic [7:0]  strobes;	// l2 miss/wr/rd, l1d miss/wr/rd, l1i miss/rd
	logic        rpt_ready;
	logic        rpt_valid;
	logic [7:0]  rpt_data;
	logic        rpt_last;
	logic [31:0] rng_state;

	// Reference model
	logic [7:0]  prev_strobes;
	logic [11:0] cnt_acc [3];
	logic [11:0] cnt_miss [3];
	logic [11:0] lat_acc [3];
	logic [11:0] lat_miss [3];
	logic [2:0]  pend;	// Level holds a record not yet fully sent
	logic        active;
	int          cur;
	int          pos;
	int          last_served;
	int          edge_no;
	int          records_done;
	int          drops;
	int          dual_edges;
	int          l2_acc_total;

	logic        exp_valid;
	int          exp_lvl;
	logic [7:0]  exp_data;
	logic        exp_last;

	cache_perf_monitor #(.SNAP_PERIOD(SNAP_PERIOD)) cache_perf_monitor_inst (
		.clk         (clk),
		.rstn        (rstn),
		.read_l1i_i  (strobes[0]),
		.miss_l1i_i  (strobes[1]),
		.read_l1d_i  (strobes[2]),
		.write_l1d_i (strobes[3]),
		.miss_l1d_i  (strobes[4]),
		.read_l2_i   (strobes[5]),
		.write_l2_i  (strobes[6]),
		.miss_l2_i   (strobes[7]),
		.rpt_valid_o (rpt_valid),
		.rpt_data_o  (rpt_data),
		.rpt_last_o  (rpt_last),
		.rpt_ready_i (rpt_ready)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [7:0] expected_byte(int lvl, int idx, logic [11:0] miss,
		logic [11:0] acc);
		string       hex_chars;
		string       tags;
		logic [23:0] both;
		hex_chars = "0123456789ABCDEF";
		tags      = "abc";
		both      = {miss, acc};
		if (idx == 0) begin
			return tags[lvl];
		end
		return hex_chars[both[4 * (6 - idx) +: 4]];
	endfunction

	function automatic logic is_upper_hex(logic [7:0] c);
		return (c >= "0" && c <= "9") || (c >= "A" && c <= "F");
	endfunction

	task automatic fail_run(string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic value_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		fail_run($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual));
	endtask

	task automatic drive_slot();
		@(posedge clk);
		#0.5;
	endtask

	task automatic drive_random(logic stall, logic l2_toggle);
		logic [31:0] r;
		drive_slot();
		r = next_rand();
		if (l2_toggle) begin
			strobes = {r[31], {2{~strobes[5]}}, r[28:24]};	// L2 read and write rise together
		end else begin
			strobes = r[31:24];
		end
		rpt_ready = !stall && (((next_rand() >> 8) % 100) < 70);
	endtask

	// Next pending level after the one last served, lowest offset wins
	always_comb begin : expect_next
		int cand;
		cand = 0;
		for (int k = 3; k >= 1; k--) begin
			if (pend[(last_served + k) % 3]) begin
				cand = (last_served + k) % 3;
			end
		end
		exp_valid = active || (pend != 3'b000);
		exp_lvl   = active ? cur : cand;
		exp_data  = expected_byte(exp_lvl, pos, lat_miss[exp_lvl], lat_acc[exp_lvl]);
		exp_last  = (pos == 6);
	end

	always @(posedge clk) begin : ref_model
		logic [7:0]  rise;
		logic [11:0] acc_now [3];
		logic [11:0] miss_now [3];
		logic        snap_now;
		logic        hs;
		int          n_drop;
		if (!rstn) begin
			prev_strobes <= '0;
			pend         <= '0;
			active       <= 1'b0;
			cur          <= 0;
			pos          <= 0;
			last_served  <= 2;	// L1I goes first
			edge_no      <= 0;
			records_done <= 0;
			drops        <= 0;
			dual_edges   <= 0;
			l2_acc_total <= 0;
			for (int l = 0; l < 3; l++) begin
				cnt_acc[l]  <= '0;
				cnt_miss[l] <= '0;
			end
		end else begin
			rise        = strobes & ~prev_strobes;
			acc_now[0]  = cnt_acc[0] + 12'(rise[0]);
			miss_now[0] = cnt_miss[0] + 12'(rise[1]);
			acc_now[1]  = cnt_acc[1] + 12'(rise[2]) + 12'(rise[3]);
			miss_now[1] = cnt_miss[1] + 12'(rise[4]);
			acc_now[2]  = cnt_acc[2] + 12'(rise[5]) + 12'(rise[6]);
			miss_now[2] = cnt_miss[2] + 12'(rise[7]);
			snap_now    = ((edge_no + 1) % SNAP_PERIOD) == 0;
			hs          = exp_valid && rpt_ready;
			n_drop      = 0;
			prev_strobes <= strobes;
			edge_no      <= edge_no + 1;
			l2_acc_total <= l2_acc_total + int'(rise[5]) + int'(rise[6]);
			if ((rise[2] && rise[3]) || (rise[5] && rise[6])) begin
				dual_edges <= dual_edges + 1;
			end
			if (exp_valid) begin
				if (hs && exp_last) begin
					pend[exp_lvl] <= 1'b0;
					active        <= 1'b0;
					pos           <= 0;
					last_served   <= exp_lvl;
					records_done  <= records_done + 1;
				end else begin
					active <= 1'b1;	// Grant holds from the first presented byte
					cur    <= exp_lvl;
					pos    <= pos + int'(hs);
				end
			end
			for (int l = 0; l < 3; l++) begin
				cnt_acc[l]  <= acc_now[l];
				cnt_miss[l] <= miss_now[l];
				if (snap_now && pend[l]) begin
					n_drop++;
				end else if (snap_now) begin
					pend[l]     <= 1'b1;
					lat_acc[l]  <= acc_now[l];
					lat_miss[l] <= miss_now[l];
				end
			end
			drops <= drops + n_drop;
		end
	end

	a_idle_before_snap: assert property (@(posedge clk) disable iff (!rstn)
		edge_no < SNAP_PERIOD |-> !rpt_valid
	) else value_mismatch("rpt_valid_o", 0, $sampled(rpt_valid));

	a_valid: assert property (@(posedge clk) disable iff (!rstn)
		rpt_valid == exp_valid
	) else value_mismatch("rpt_valid_o", $sampled(exp_valid), $sampled(rpt_valid));

	a_data: assert property (@(posedge clk) disable iff (!rstn)
		exp_valid |-> rpt_data == exp_data
	) else value_mismatch("rpt_data_o", $sampled(exp_data), $sampled(rpt_data));

	a_last: assert property (@(posedge clk) disable iff (!rstn)
		exp_valid |-> rpt_last == exp_last
	) else value_mismatch("rpt_last_o", $sampled(exp_last), $sampled(rpt_last));

	a_digit: assert property (@(posedge clk) disable iff (!rstn)
		exp_valid && pos != 0 |-> is_upper_hex(rpt_data)
	) else fail_run($sformatf("CHECK FAILED rpt_data_o 0x%02h is not an uppercase hex digit",
		$sampled(rpt_data)));

	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		rpt_valid && !rpt_ready |=> rpt_valid && $stable(rpt_data) && $stable(rpt_last)
	) else fail_run($sformatf("CHECK FAILED rpt_data_o 0x%02h rpt_last_o 0x%0h changed while held",
		$sampled(rpt_data), $sampled(rpt_last)));

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		fail_run("Timeout: the run did not finish within the cycle limit");
	end

	initial begin
		clk       = 1'b0;
		rstn      = 1'b0;
		strobes   = '0;
		rpt_ready = 1'b0;
		rng_state = 32'h7d94_9813;
		repeat (10) @(posedge clk);
		#0.5;
		rstn = 1'b1;
		repeat (PHASE1_CYCLES) drive_random(1'b0, 1'b0);
		repeat (STALL_CYCLES) drive_random(1'b1, 1'b0);	// Snaps during the stall get dropped
		repeat (WRAP_CYCLES) drive_random(1'b0, 1'b1);
		repeat (DRAIN_CYCLES) begin
			drive_slot();
			strobes   = '0;
			rpt_ready = 1'b1;
		end
		while (pend != 3'b000) begin
			drive_slot();
		end
		if (records_done < MIN_RECORDS || drops == 0 || dual_edges == 0 || l2_acc_total < 4096) begin
			fail_run("The stimulus did not reach every checked behavior");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* src/cache_perf_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_perf_monitor #(
	parameter int SNAP_PERIOD = 120
) (
	input  wire logic       clk,
	input  wire logic       rstn,
	input  wire logic       read_l1i_i,
	input  wire logic       miss_l1i_i,
	input  wire logic       read_l1d_i,
	input  wire logic       write_l1d_i,
	input  wire logic       miss_l1d_i,
	input  wire logic       read_l2_i,
	input  wire logic       write_l2_i,
	input  wire logic       miss_l2_i,
	output logic            rpt_valid_o,
	output perf_pkg::byte_t rpt_data_o,
	output logic            rpt_last_o,
	input  wire logic       rpt_ready_i
);
	import perf_pkg::*;

	count_t access_cnt [NUM_LEVELS];
	count_t miss_cnt   [NUM_LEVELS];
	logic   snap;

	byte_stream_if rpt_if [NUM_LEVELS] ();

	event_edge_counter #(.NUM_ACCESS(1)) l1i_counter_inst (
		.clk          (clk),
		.rstn         (rstn),
		.access_i     (read_l1i_i),
		.miss_i       (miss_l1i_i),
		.access_cnt_o (access_cnt[0]),
		.miss_cnt_o   (miss_cnt[0])
	);

	event_edge_counter #(.NUM_ACCESS(2)) l1d_counter_inst (
		.clk          (clk),
		.rstn         (rstn),
		.access_i     ({write_l1d_i, read_l1d_i}),
		.miss_i       (miss_l1d_i),
		.access_cnt_o (access_cnt[1]),
		.miss_cnt_o   (miss_cnt[1])
	);

	event_edge_counter #(.NUM_ACCESS(2)) l2_counter_inst (
		.clk          (clk),
		.rstn         (rstn),
		.access_i     ({write_l2_i, read_l2_i}),
		.miss_i       (miss_l2_i),
		.access_cnt_o (access_cnt[2]),
		.miss_cnt_o   (miss_cnt[2])
	);

	snapshot_timer #(.SNAP_PERIOD(SNAP_PERIOD)) snapshot_timer_inst (
		.clk    (clk),
		.rstn   (rstn),
		.snap_o (snap)
	);

	level_reporter #(.LEVEL(LVL_L1I)) l1i_reporter_inst (
		.clk          (clk),
		.rstn         (rstn),
		.snap_i       (snap),
		.access_cnt_i (access_cnt[0]),
		.miss_cnt_i   (miss_cnt[0]),
		.rpt          (rpt_if[0])
	);

	level_reporter #(.LEVEL(LVL_L1D)) l1d_reporter_inst (
		.clk          (clk),
		.rstn         (rstn),
		.snap_i       (snap),
		.access_cnt_i (access_cnt[1]),
		.miss_cnt_i   (miss_cnt[1]),
		.rpt          (rpt_if[1])
	);

	level_reporter #(.LEVEL(LVL_L2)) l2_reporter_inst (
		.clk          (clk),
		.rstn         (rstn),
		.snap_i       (snap),
		.access_cnt_i (access_cnt[2]),
		.miss_cnt_i   (miss_cnt[2]),
		.rpt          (rpt_if[2])
	);

	report_arbiter #(.N_SRC(NUM_LEVELS)) report_arbiter_inst (
		.clk         (clk),
		.rstn        (rstn),
		.src         (rpt_if),
		.out_valid_o (rpt_valid_o),
		.out_data_o  (rpt_data_o),
		.out_last_o  (rpt_last_o),
		.out_ready_i (rpt_ready_i)
	);

endmodule

`default_nettype wire

/* src/report_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module report_arbiter #(
	parameter int N_SRC = 3
) (
	input  wire logic   clk,
	input  wire logic   rstn,
	byte_stream_if.sink src [N_SRC],
	output logic        out_valid_o,
	output perf_pkg::byte_t out_data_o,
	output logic        out_last_o,
	input  wire logic   out_ready_i
);
	import perf_pkg::*;

	localparam int GRANT_W = (N_SRC > 1) ? $clog2(N_SRC) : 1;

	logic [N_SRC-1:0]   req;
	logic [N_SRC-1:0]   last_vec;
	logic [N_SRC-1:0]   ready_vec;
	byte_t              data_arr [N_SRC];
	logic [GRANT_W-1:0] grant_q;
	logic [GRANT_W-1:0] pick;
	logic [GRANT_W-1:0] sel;
	logic               locked_q;
	logic               found;

	for (genvar i = 0; i < N_SRC; i++) begin : g_src
		assign req[i]       = src[i].valid;
		assign last_vec[i]  = src[i].last;
		assign data_arr[i]  = src[i].data;
		assign ready_vec[i] = out_ready_i && (sel == GRANT_W'(i));
		assign src[i].ready = ready_vec[i];
	end

	// Search starts just after the last level served
	always_comb begin
		pick  = grant_q;
		found = 1'b0;
		for (int k = 1; k <= N_SRC; k++) begin
			if (!found && req[(int'(grant_q) + k) % N_SRC]) begin
				pick  = GRANT_W'((int'(grant_q) + k) % N_SRC);
				found = 1'b1;
			end
		end
	end

	assign sel = locked_q ? grant_q : pick;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			locked_q <= 1'b0;
			grant_q  <= GRANT_W'(N_SRC - 1);	// L1I first after reset
		end else if (out_valid_o) begin
			grant_q  <= sel;
			locked_q <= !(out_ready_i && out_last_o);	// Release after record end
		end
	end

	assign out_valid_o = req[sel];
	assign out_data_o  = data_arr[sel];
	assign out_last_o  = last_vec[sel];

	// Mid-record the locked source stays valid and alone sees ready
	a_ready_granted: assert property (
		@(posedge clk) disable iff (!rstn)
		locked_q |->
			req[grant_q] && ((ready_vec & ~(N_SRC'(1) << grant_q)) == '0)
	) else $error("Granted source dropped its record or ready reached another source");

endmodule

`default_nettype wire

/* src/level_reporter.sv */
`timescale 1ns/1ps
`default_nettype none

module level_reporter #(
	parameter perf_pkg::level_e LEVEL = perf_pkg::LVL_L1I
) (
	input  wire logic             clk,
	input  wire logic             rstn,
	input  wire logic             snap_i,
	input  wire perf_pkg::count_t access_cnt_i,
	input  wire perf_pkg::count_t miss_cnt_i,
	byte_stream_if.source         rpt
);
	import perf_pkg::*;

	localparam int IDX_W = $clog2(REC_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(REC_LEN - 1);

	logic               busy_q;
	logic [IDX_W-1:0]   idx_q;
	logic [2*CNT_W-1:0] rec_cnt_q;	// Miss count above access count
	logic [3:0]         nibble;
	logic               take_snap;
	logic               hs;

	assign take_snap = snap_i && !busy_q;	// Busy snaps are dropped
	assign hs        = rpt.valid && rpt.ready;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q <= 1'b0;
			idx_q  <= '0;
		end else if (take_snap) begin
			busy_q <= 1'b1;
			idx_q  <= '0;
		end else if (hs) begin
			if (idx_q == LAST_IDX) begin
				busy_q <= 1'b0;
				idx_q  <= '0;
			end else begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_snap) begin
			rec_cnt_q <= {miss_cnt_i, access_cnt_i};
		end
	end

	// Byte 1 takes the top miss nibble, byte 6 the bottom access nibble
	assign nibble = 4'(rec_cnt_q >> (4 * (REC_LEN - 1 - int'(idx_q))));

	always_comb begin
		if (idx_q == '0) begin
			rpt.data = level_tag(LEVEL);
		end else begin
			rpt.data = hex_ascii(nibble);
		end
	end

	assign rpt.valid = busy_q;
	assign rpt.last  = busy_q && (idx_q == LAST_IDX);

	// A held byte must not change under the sink
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!rstn)
		rpt.valid && !rpt.ready |=>
			rpt.valid && $stable(rpt.data) && $stable(rpt.last)
	) else $error("Reporter changed a byte while it was held by back-pressure");

endmodule

`default_nettype wire

/* src/snapshot_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module snapshot_timer #(
	parameter int SNAP_PERIOD = 120
) (
	input  wire logic clk,
	input  wire logic rstn,
	output logic      snap_o
);

	localparam int TMR_W = (SNAP_PERIOD > 1) ? $clog2(SNAP_PERIOD) : 1;
	localparam logic [TMR_W-1:0] TERMINAL = TMR_W'(SNAP_PERIOD - 1);

	logic [TMR_W-1:0] tmr_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			tmr_q <= '0;
		end else if (tmr_q == TERMINAL) begin
			tmr_q <= '0;
		end else begin
			tmr_q <= tmr_q + 1'b1;
		end
	end

	// First pulse in cycle SNAP_PERIOD-1 after reset
	assign snap_o = (tmr_q == TERMINAL);

endmodule

`default_nettype wire

/* src/event_edge_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module event_edge_counter #(
	parameter int NUM_ACCESS = 1
) (
	input  wire logic                  clk,
	input  wire logic                  rstn,
	input  wire logic [NUM_ACCESS-1:0] access_i,
	input  wire logic                  miss_i,
	output perf_pkg::count_t           access_cnt_o,
	output perf_pkg::count_t           miss_cnt_o
);
	import perf_pkg::*;

	localparam int INC_W = $clog2(NUM_ACCESS + 1);

	logic [NUM_ACCESS-1:0] access_prev_q;
	logic                  miss_prev_q;
	logic [NUM_ACCESS-1:0] access_rise;
	logic                  miss_rise;
	logic [INC_W-1:0]      access_inc;
	count_t                access_cnt_q;
	count_t                miss_cnt_q;

	assign access_rise = access_i & ~access_prev_q;
	assign miss_rise   = miss_i & ~miss_prev_q;

	// Read and write edges in one cycle both count
	always_comb begin
		access_inc = '0;
		for (int k = 0; k < NUM_ACCESS; k++) begin
			access_inc = access_inc + INC_W'(access_rise[k]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			access_prev_q <= '0;
			miss_prev_q   <= 1'b0;
			access_cnt_q  <= '0;
			miss_cnt_q    <= '0;
		end else begin
			access_prev_q <= access_i;
			miss_prev_q   <= miss_i;
			access_cnt_q  <= access_cnt_o;	// Wraps at 12 bits
			miss_cnt_q    <= miss_cnt_o;
		end
	end

	// Counts as of this edge, so a snapshot taken now includes the current edge
	assign access_cnt_o = access_cnt_q + count_t'(access_inc);
	assign miss_cnt_o   = miss_cnt_q + count_t'(miss_rise);

endmodule

`default_nettype wire

/* common/byte_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;
	import perf_pkg::*;

	logic  valid;
	logic  ready;
	byte_t data;
	logic  last;	// Final byte of a record

	modport source (
		output valid,
		output data,
		output last,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  last,
		output ready
	);

endinterface

`default_nettype wire

/* common/perf_pkg.sv */
`default_nettype none

package perf_pkg;

	localparam int CNT_W      = 12;
	localparam int HEX_DIGITS = CNT_W / 4;
	localparam int REC_LEN    = 1 + 2 * HEX_DIGITS;	// Tag, miss digits, access digits
	localparam int NUM_LEVELS = 3;

	typedef logic [7:0]       byte_t;
	typedef logic [CNT_W-1:0] count_t;

	typedef enum logic [1:0] {
		LVL_L1I,
		LVL_L1D,
		LVL_L2
	} level_e;

	function automatic byte_t level_tag(level_e lvl);
		case (lvl)
			LVL_L1I: return "a";
			LVL_L1D: return "b";
			default: return "c";
		endcase
	endfunction

	// Uppercase hex digit
	function automatic byte_t hex_ascii(logic [3:0] nib);
		if (nib < 4'd10) begin
			return byte_t'(8'h30 + nib);
		end
		return byte_t'(8'h37 + nib);	// 'A' minus 10
	endfunction

endpackage

`default_nettype wire
